/* tcdm_cfg.svh */
// --------------------------------------
// Tile count and bank depth must be powers of two
// Data width must be a whole number of bytes
// --------------------------------------

`ifndef TCDM_CFG_SVH
`define TCDM_CFG_SVH

// Number of tile masters
// One bank per tile, so this is also the bank count
`define TCDM_NUM_TILES 4

// Words held by each bank
`define TCDM_BANK_WORDS 64

// Data word width in bits
`define TCDM_DATA_W 32

`endif

/* tcdm_pkg.sv */
// --------------------------------------
// Word addresses are interleaved across banks
// The low address bits select the bank
// --------------------------------------

`include "tcdm_cfg.svh"

package tcdm_pkg;

  // Word address over the whole scratchpad
  typedef logic [$clog2(`TCDM_NUM_TILES * `TCDM_BANK_WORDS)-1:0] tcdm_addr_t;

  typedef logic [$clog2(`TCDM_NUM_TILES)-1:0] bank_sel_t;
  typedef logic [$clog2(`TCDM_BANK_WORDS)-1:0] bank_row_t;

  typedef logic [`TCDM_DATA_W-1:0] tcdm_data_t;
  typedef logic [`TCDM_DATA_W/8-1:0] tcdm_strb_t;

  // Tiles take the low ids, the DMA the highest
  typedef logic [$clog2(`TCDM_NUM_TILES + 1)-1:0] ini_id_t;

  // One extra bit so a full-scratchpad copy fits
  typedef logic [$bits(tcdm_addr_t):0] dma_len_t;

  typedef enum logic [2:0] {
    DMA_IDLE,
    DMA_READ,
    DMA_READ_WAIT,
    DMA_WRITE,
    DMA_WRITE_WAIT
  } dma_state_e;

endpackage

/* tcdm_bank.sv */
// --------------------------------------
// Always ready, response one cycle after request
// Read data is undefined on write responses
// --------------------------------------

`include "tcdm_cfg.svh"

module tcdm_bank
  import tcdm_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       req_i,
  input  logic       wen_i,
  input  bank_row_t  row_i,
  input  tcdm_data_t wdata_i,
  input  tcdm_strb_t be_i,
  input  ini_id_t    ini_i,
  output logic       resp_valid_o,
  output ini_id_t    resp_ini_o,
  output tcdm_data_t rdata_o
);

  tcdm_data_t mem_q [`TCDM_BANK_WORDS];
  tcdm_data_t rdata_q;
  ini_id_t    resp_ini_q;
  logic       resp_valid_q;

  // Byte-masked write or word read
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (wen_i) begin
        for (int b = 0; b < $bits(tcdm_strb_t); b++) begin
          if (be_i[b]) begin
            mem_q[row_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[row_i];
      end
      resp_ini_q <= ini_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= req_i;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_ini_o   = resp_ini_q;
  assign rdata_o      = rdata_q;

endmodule

/* bank_arbiter.sv */
// --------------------------------------
// Grant is combinational on the request vector
// A waiting requester wins within one full turn
// --------------------------------------

`include "tcdm_cfg.svh"

module bank_arbiter
  import tcdm_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic [`TCDM_NUM_TILES:0] req_i,
  output logic [`TCDM_NUM_TILES:0] gnt_o,
  output ini_id_t                  gnt_idx_o
);

  localparam int unsigned NumReq = `TCDM_NUM_TILES + 1;

  // Requester with the highest priority this cycle
  ini_id_t rr_q;

  // Scan from the pointer upward with wrap
  always_comb begin
    int unsigned idx;
    logic        found;
    gnt_o     = '0;
    gnt_idx_o = '0;
    found     = 1'b0;
    for (int unsigned i = 0; i < NumReq; i++) begin
      idx = int'(rr_q) + i;
      if (idx >= NumReq) begin
        idx = idx - NumReq;
      end
      if (!found && req_i[idx]) begin
        found      = 1'b1;
        gnt_o[idx] = 1'b1;
        gnt_idx_o  = ini_id_t'(idx);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q <= '0;
    end else if (|req_i) begin
      if (gnt_idx_o == ini_id_t'(NumReq - 1)) begin
        rr_q <= '0;
      end else begin
        rr_q <= gnt_idx_o + ini_id_t'(1);
      end
    end
  end

endmodule

/* local_interco.sv */
// --------------------------------------
// Purely combinational, no added latency
// Responses follow the id stored by each bank
// --------------------------------------

`include "tcdm_cfg.svh"

module local_interco
  import tcdm_pkg::*;
(
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  // Initiator requests
  input  logic       [`TCDM_NUM_TILES:0]         ini_valid_i,
  input  tcdm_addr_t [`TCDM_NUM_TILES:0]         ini_addr_i,
  input  logic       [`TCDM_NUM_TILES:0]         ini_wen_i,
  input  tcdm_data_t [`TCDM_NUM_TILES:0]         ini_wdata_i,
  input  tcdm_strb_t [`TCDM_NUM_TILES:0]         ini_be_i,
  output logic       [`TCDM_NUM_TILES:0]         ini_ready_o,
  // Initiator responses
  output logic       [`TCDM_NUM_TILES:0]         ini_resp_valid_o,
  output tcdm_data_t [`TCDM_NUM_TILES:0]         ini_resp_rdata_o,
  // Bank requests
  output logic       [`TCDM_NUM_TILES-1:0]       bank_req_o,
  output logic       [`TCDM_NUM_TILES-1:0]       bank_wen_o,
  output bank_row_t  [`TCDM_NUM_TILES-1:0]       bank_row_o,
  output tcdm_data_t [`TCDM_NUM_TILES-1:0]       bank_wdata_o,
  output tcdm_strb_t [`TCDM_NUM_TILES-1:0]       bank_be_o,
  output ini_id_t    [`TCDM_NUM_TILES-1:0]       bank_ini_o,
  // Bank responses
  input  logic       [`TCDM_NUM_TILES-1:0]       bank_resp_valid_i,
  input  ini_id_t    [`TCDM_NUM_TILES-1:0]       bank_resp_ini_i,
  input  tcdm_data_t [`TCDM_NUM_TILES-1:0]       bank_rdata_i
);

  localparam int unsigned NumIni  = `TCDM_NUM_TILES + 1;
  localparam int unsigned NumBank = `TCDM_NUM_TILES;
  localparam int unsigned SelW    = $bits(bank_sel_t);

  bank_sel_t [NumIni-1:0]               ini_bank;
  bank_row_t [NumIni-1:0]               ini_row;
  logic      [NumBank-1:0][NumIni-1:0]  bank_mask;
  logic      [NumBank-1:0][NumIni-1:0]  bank_gnt;
  ini_id_t   [NumBank-1:0]              bank_gnt_idx;

  // --------------------------------------
  // Address decode
  // --------------------------------------

  for (genvar i = 0; i < NumIni; i++) begin : gen_decode
    assign ini_bank[i] = ini_addr_i[i][SelW-1:0];
    assign ini_row[i]  = ini_addr_i[i][$bits(tcdm_addr_t)-1:SelW];

    for (genvar b = 0; b < NumBank; b++) begin : gen_mask
      assign bank_mask[b][i] = ini_valid_i[i] && (ini_bank[i] == bank_sel_t'(b));
    end
  end

  // --------------------------------------
  // Per-bank arbitration
  // --------------------------------------

  for (genvar b = 0; b < NumBank; b++) begin : gen_bank
    bank_arbiter i_bank_arbiter (
      .clk_i    (clk_i          ),
      .rst_n_i  (rst_n_i        ),
      .req_i    (bank_mask[b]   ),
      .gnt_o    (bank_gnt[b]    ),
      .gnt_idx_o(bank_gnt_idx[b])
    );

    // Winner's payload to the bank
    assign bank_req_o[b]   = |bank_mask[b];
    assign bank_wen_o[b]   = ini_wen_i[bank_gnt_idx[b]];
    assign bank_row_o[b]   = ini_row[bank_gnt_idx[b]];
    assign bank_wdata_o[b] = ini_wdata_i[bank_gnt_idx[b]];
    assign bank_be_o[b]    = ini_be_i[bank_gnt_idx[b]];
    assign bank_ini_o[b]   = bank_gnt_idx[b];
  end

  // An initiator targets one bank, so at most one grant is set
  always_comb begin
    ini_ready_o = '0;
    for (int unsigned b = 0; b < NumBank; b++) begin
      ini_ready_o = ini_ready_o | bank_gnt[b];
    end
  end

  // --------------------------------------
  // Response routing
  // --------------------------------------

  always_comb begin
    ini_resp_valid_o = '0;
    ini_resp_rdata_o = '0;
    for (int unsigned b = 0; b < NumBank; b++) begin
      for (int unsigned i = 0; i < NumIni; i++) begin
        if (bank_resp_valid_i[b] && (bank_resp_ini_i[b] == ini_id_t'(i))) begin
          ini_resp_valid_o[i] = 1'b1;
          ini_resp_rdata_o[i] = bank_rdata_i[b];
        end
      end
    end
  end

endmodule

/* dma_copy_engine.sv */
// --------------------------------------
// One word in flight, copied in rising address order
// Addresses wrap at the end of the scratchpad
// --------------------------------------

`include "tcdm_cfg.svh"

module dma_copy_engine
  import tcdm_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  // Command
  input  tcdm_addr_t dma_src_i,
  input  tcdm_addr_t dma_dst_i,
  input  dma_len_t   dma_len_i,
  input  logic       dma_valid_i,
  output logic       dma_ready_o,
  output logic       dma_busy_o,
  output logic       dma_done_o,
  // Scratchpad request
  output logic       req_valid_o,
  output tcdm_addr_t req_addr_o,
  output logic       req_wen_o,
  output tcdm_data_t req_wdata_o,
  output tcdm_strb_t req_be_o,
  input  logic       req_ready_i,
  // Scratchpad response
  input  logic       resp_valid_i,
  input  tcdm_data_t resp_rdata_i
);

  dma_state_e state_q;
  tcdm_addr_t src_q;
  tcdm_addr_t dst_q;
  dma_len_t   cnt_q;
  tcdm_data_t data_q;
  logic       done_q;

  // Read state doubles as the loop head and exit test
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= DMA_IDLE;
      src_q   <= '0;
      dst_q   <= '0;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        DMA_IDLE: begin
          if (dma_valid_i) begin
            src_q   <= dma_src_i;
            dst_q   <= dma_dst_i;
            cnt_q   <= dma_len_i;
            state_q <= DMA_READ;
          end
        end
        DMA_READ: begin
          if (cnt_q == '0) begin
            done_q  <= 1'b1;
            state_q <= DMA_IDLE;
          end else if (req_ready_i) begin
            state_q <= DMA_READ_WAIT;
          end
        end
        DMA_READ_WAIT: begin
          if (resp_valid_i) begin
            state_q <= DMA_WRITE;
          end
        end
        DMA_WRITE: begin
          if (req_ready_i) begin
            state_q <= DMA_WRITE_WAIT;
          end
        end
        DMA_WRITE_WAIT: begin
          if (resp_valid_i) begin
            src_q   <= src_q + tcdm_addr_t'(1);
            dst_q   <= dst_q + tcdm_addr_t'(1);
            cnt_q   <= cnt_q - dma_len_t'(1);
            state_q <= DMA_READ;
          end
        end
        default: state_q <= DMA_IDLE;
      endcase
    end
  end

  // Word held between its read and its write
  always_ff @(posedge clk_i) begin
    if (state_q == DMA_READ_WAIT && resp_valid_i) begin
      data_q <= resp_rdata_i;
    end
  end

  assign req_valid_o = ((state_q == DMA_READ) && (cnt_q != '0)) || (state_q == DMA_WRITE);
  assign req_wen_o   = (state_q == DMA_WRITE);
  assign req_addr_o  = (state_q == DMA_WRITE) ? dst_q : src_q;
  assign req_wdata_o = data_q;
  assign req_be_o    = '1;

  assign dma_ready_o = (state_q == DMA_IDLE);
  assign dma_busy_o  = (state_q != DMA_IDLE);
  assign dma_done_o  = done_q;

endmodule

/* tcdm_group.sv */
// --------------------------------------
// Tiles must take each response when it arrives
// The DMA is the last initiator on every bank
// --------------------------------------

`include "tcdm_cfg.svh"

module tcdm_group
  import tcdm_pkg::*;
(
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  // Tile requests
  input  logic       [`TCDM_NUM_TILES-1:0]     tile_req_valid_i,
  input  tcdm_addr_t [`TCDM_NUM_TILES-1:0]     tile_req_addr_i,
  input  logic       [`TCDM_NUM_TILES-1:0]     tile_req_wen_i,
  input  tcdm_data_t [`TCDM_NUM_TILES-1:0]     tile_req_wdata_i,
  input  tcdm_strb_t [`TCDM_NUM_TILES-1:0]     tile_req_be_i,
  output logic       [`TCDM_NUM_TILES-1:0]     tile_req_ready_o,
  // Tile responses
  output logic       [`TCDM_NUM_TILES-1:0]     tile_resp_valid_o,
  output tcdm_data_t [`TCDM_NUM_TILES-1:0]     tile_resp_rdata_o,
  // DMA command and status
  input  tcdm_addr_t                           dma_src_i,
  input  tcdm_addr_t                           dma_dst_i,
  input  dma_len_t                             dma_len_i,
  input  logic                                 dma_valid_i,
  output logic                                 dma_ready_o,
  output logic                                 dma_busy_o,
  output logic                                 dma_done_o
);

  localparam int unsigned NumTiles = `TCDM_NUM_TILES;

  // DMA side of the interconnect
  logic       dma_req_valid;
  tcdm_addr_t dma_req_addr;
  logic       dma_req_wen;
  tcdm_data_t dma_req_wdata;
  tcdm_strb_t dma_req_be;

  // Initiator vectors, DMA on top
  logic       [NumTiles:0] ini_ready;
  logic       [NumTiles:0] ini_resp_valid;
  tcdm_data_t [NumTiles:0] ini_resp_rdata;

  logic       [NumTiles-1:0] bank_req;
  logic       [NumTiles-1:0] bank_wen;
  bank_row_t  [NumTiles-1:0] bank_row;
  tcdm_data_t [NumTiles-1:0] bank_wdata;
  tcdm_strb_t [NumTiles-1:0] bank_be;
  ini_id_t    [NumTiles-1:0] bank_ini;
  logic       [NumTiles-1:0] bank_resp_valid;
  ini_id_t    [NumTiles-1:0] bank_resp_ini;
  tcdm_data_t [NumTiles-1:0] bank_rdata;

  assign tile_req_ready_o  = ini_ready[NumTiles-1:0];
  assign tile_resp_valid_o = ini_resp_valid[NumTiles-1:0];
  assign tile_resp_rdata_o = ini_resp_rdata[NumTiles-1:0];

  local_interco i_local_interco (
    .clk_i            (clk_i                              ),
    .rst_n_i          (rst_n_i                            ),
    .ini_valid_i      ({dma_req_valid, tile_req_valid_i}  ),
    .ini_addr_i       ({dma_req_addr, tile_req_addr_i}    ),
    .ini_wen_i        ({dma_req_wen, tile_req_wen_i}      ),
    .ini_wdata_i      ({dma_req_wdata, tile_req_wdata_i}  ),
    .ini_be_i         ({dma_req_be, tile_req_be_i}        ),
    .ini_ready_o      (ini_ready                          ),
    .ini_resp_valid_o (ini_resp_valid                     ),
    .ini_resp_rdata_o (ini_resp_rdata                     ),
    .bank_req_o       (bank_req                           ),
    .bank_wen_o       (bank_wen                           ),
    .bank_row_o       (bank_row                           ),
    .bank_wdata_o     (bank_wdata                         ),
    .bank_be_o        (bank_be                            ),
    .bank_ini_o       (bank_ini                           ),
    .bank_resp_valid_i(bank_resp_valid                    ),
    .bank_resp_ini_i  (bank_resp_ini                      ),
    .bank_rdata_i     (bank_rdata                         )
  );

  for (genvar b = 0; b < NumTiles; b++) begin : gen_banks
    tcdm_bank i_tcdm_bank (
      .clk_i       (clk_i             ),
      .rst_n_i     (rst_n_i           ),
      .req_i       (bank_req[b]       ),
      .wen_i       (bank_wen[b]       ),
      .row_i       (bank_row[b]       ),
      .wdata_i     (bank_wdata[b]     ),
      .be_i        (bank_be[b]        ),
      .ini_i       (bank_ini[b]       ),
      .resp_valid_o(bank_resp_valid[b]),
      .resp_ini_o  (bank_resp_ini[b]  ),
      .rdata_o     (bank_rdata[b]     )
    );
  end

  dma_copy_engine i_dma_copy_engine (
    .clk_i       (clk_i                   ),
    .rst_n_i     (rst_n_i                 ),
    .dma_src_i   (dma_src_i               ),
    .dma_dst_i   (dma_dst_i               ),
    .dma_len_i   (dma_len_i               ),
    .dma_valid_i (dma_valid_i             ),
    .dma_ready_o (dma_ready_o             ),
    .dma_busy_o  (dma_busy_o              ),
    .dma_done_o  (dma_done_o              ),
    .req_valid_o (dma_req_valid           ),
    .req_addr_o  (dma_req_addr            ),
    .req_wen_o   (dma_req_wen             ),
    .req_wdata_o (dma_req_wdata           ),
    .req_be_o    (dma_req_be              ),
    .req_ready_i (ini_ready[NumTiles]     ),
    .resp_valid_i(ini_resp_valid[NumTiles]),
    .resp_rdata_i(ini_resp_rdata[NumTiles])
  );

endmodule

/* tb_tcdm_group.sv */
// --------------------------------------
// Memory is filled with full-word writes before any read
// Tile reads during a copy stay away from its destination
// --------------------------------------

`include "tcdm_cfg.svh"

module tb_tcdm_group
  import tcdm_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumTiles  = `TCDM_NUM_TILES;
  localparam int MemWords  = `TCDM_NUM_TILES * `TCDM_BANK_WORDS;
  localparam int ClkPeriod = 8;
  // Upper bound on tile and DMA accesses over all tests
  localparam int TotalOps  = 3000;

  logic                         clk_i = 1'b0;
  logic                         rst_n_i;
  logic       [NumTiles-1:0]    tile_req_valid_i;
  tcdm_addr_t [NumTiles-1:0]    tile_req_addr_i;
  logic       [NumTiles-1:0]    tile_req_wen_i;
  tcdm_data_t [NumTiles-1:0]    tile_req_wdata_i;
  tcdm_strb_t [NumTiles-1:0]    tile_req_be_i;
  logic       [NumTiles-1:0]    tile_req_ready_o;
  logic       [NumTiles-1:0]    tile_resp_valid_o;
  tcdm_data_t [NumTiles-1:0]    tile_resp_rdata_o;
  tcdm_addr_t                   dma_src_i;
  tcdm_addr_t                   dma_dst_i;
  dma_len_t                     dma_len_i;
  logic                         dma_valid_i;
  logic                         dma_ready_o;
  logic                         dma_busy_o;
  logic                         dma_done_o;

  tcdm_data_t model [MemWords];
  logic       pend [NumTiles];
  logic       pend_rd [NumTiles];
  tcdm_data_t pend_exp [NumTiles];
  int         wait_cnt [NumTiles];
  string      cur_test = "reset";
  logic       copy_running = 1'b0;

  tcdm_group tcdm_group_i (.*);

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  task automatic report_fail(string name, logic [63:0] exp, logic [63:0] act);
    $display("Error test=%s check=%s expected=%0h actual=%0h", cur_test, name, exp, act);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // --------------------------------------
  // Monitor, sampled at the falling edge
  // --------------------------------------

  always @(negedge clk_i) begin
    int cnt;
    if (rst_n_i) begin
      for (int t = 0; t < NumTiles; t++) begin
        assert (tile_resp_valid_o[t] == pend[t])
          else report_fail($sformatf("resp_valid tile %0d", t), pend[t], tile_resp_valid_o[t]);
        if (pend[t] && pend_rd[t]) begin
          assert (tile_resp_rdata_o[t] == pend_exp[t])
            else report_fail($sformatf("rdata tile %0d", t), pend_exp[t], tile_resp_rdata_o[t]);
        end
        pend[t] = tile_req_valid_i[t] && tile_req_ready_o[t];
        pend_rd[t] = !tile_req_wen_i[t];
        if (pend[t]) begin
          wait_cnt[t] = 0;
          if (tile_req_wen_i[t]) begin
            for (int b = 0; b < $bits(tcdm_strb_t); b++) begin
              if (tile_req_be_i[t][b]) begin
                model[tile_req_addr_i[t]][8*b +: 8] = tile_req_wdata_i[t][8*b +: 8];
              end
            end
          end else begin
            pend_exp[t] = model[tile_req_addr_i[t]];
          end
        end else if (tile_req_valid_i[t]) begin
          wait_cnt[t]++;
          assert (wait_cnt[t] <= NumTiles + 1)
            else report_fail($sformatf("ready wait tile %0d", t), NumTiles + 1, wait_cnt[t]);
        end
      end
      // At most one tile granted per bank
      for (int b = 0; b < NumTiles; b++) begin
        cnt = 0;
        for (int t = 0; t < NumTiles; t++) begin
          if (tile_req_valid_i[t] && tile_req_ready_o[t] &&
              (tile_req_addr_i[t] % NumTiles == b)) begin
            cnt++;
          end
        end
        assert (cnt <= 1) else report_fail($sformatf("grants bank %0d", b), 1, cnt);
      end
    end
  end

  for (genvar t = 0; t < NumTiles; t++) begin : gen_lat
    assert property (@(negedge clk_i) disable iff (!rst_n_i)
      (tile_req_valid_i[t] && tile_req_ready_o[t]) |=> tile_resp_valid_o[t])
      else report_fail("latency", 1, 0);
  end

  assert property (@(negedge clk_i) disable iff (!rst_n_i) dma_done_o |=> !dma_done_o)
    else report_fail("done width", 0, 1);
  assert property (@(negedge clk_i) disable iff (!rst_n_i) dma_busy_o |-> !dma_ready_o)
    else report_fail("ready while busy", 0, 1);

  // --------------------------------------
  // Stimulus tasks
  // --------------------------------------

  task automatic tile_access(int t, tcdm_addr_t a, logic w, tcdm_data_t d, tcdm_strb_t be);
    tile_req_addr_i[t]  = a;
    tile_req_wen_i[t]   = w;
    tile_req_wdata_i[t] = d;
    tile_req_be_i[t]    = be;
    tile_req_valid_i[t] = 1'b1;
    forever begin
      @(negedge clk_i);
      if (tile_req_ready_o[t]) break;
    end
    @(posedge clk_i);
    #1;
    tile_req_valid_i[t] = 1'b0;
  endtask

  task automatic read_all();
    for (int a = 0; a < MemWords; a++) begin
      tile_access($urandom_range(NumTiles - 1), tcdm_addr_t'(a), 1'b0, '0, '0);
    end
  endtask

  task automatic run_dma(int src, int dst, int len);
    dma_src_i   = tcdm_addr_t'(src);
    dma_dst_i   = tcdm_addr_t'(dst);
    dma_len_i   = dma_len_t'(len);
    dma_valid_i = 1'b1;
    forever begin
      @(negedge clk_i);
      if (dma_ready_o) break;
    end
    @(posedge clk_i);
    #1;
    dma_valid_i = 1'b0;
    forever begin
      @(negedge clk_i);
      if (dma_done_o) break;
      assert (dma_busy_o && !dma_ready_o) else report_fail("busy during copy", 1, dma_busy_o);
    end
    assert (!dma_busy_o && dma_ready_o) else report_fail("busy at done", 0, dma_busy_o);
    // Copy in rising order, so overlap behaves as the engine does
    for (int i = 0; i < len; i++) begin
      model[(dst + i) % MemWords] = model[(src + i) % MemWords];
    end
    @(posedge clk_i);
    #1;
  endtask

  // --------------------------------------
  // Test sequence
  // --------------------------------------

  initial begin
    void'($urandom(15734));
    rst_n_i          = 1'b0;
    tile_req_valid_i = '0;
    tile_req_addr_i  = '0;
    tile_req_wen_i   = '0;
    tile_req_wdata_i = '0;
    tile_req_be_i    = '0;
    dma_src_i        = '0;
    dma_dst_i        = '0;
    dma_len_i        = '0;
    dma_valid_i      = 1'b0;
    for (int t = 0; t < NumTiles; t++) begin
      pend[t]     = 1'b0;
      wait_cnt[t] = 0;
    end
    repeat (16) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    @(negedge clk_i);
    assert (tile_resp_valid_o == '0) else report_fail("resp_valid", 0, tile_resp_valid_o);
    assert (!dma_busy_o && !dma_done_o) else report_fail("busy done", 0, {dma_busy_o, dma_done_o});
    assert (dma_ready_o) else report_fail("dma_ready", 1, dma_ready_o);
    @(posedge clk_i);
    #1;

    cur_test = "fill";
    for (int t = 0; t < NumTiles; t++) begin
      fork
        automatic int tt = t;
        for (int i = tt; i < MemWords; i += NumTiles) begin
          tile_access(tt, tcdm_addr_t'(i), 1'b1, tcdm_data_t'($urandom), '1);
        end
      join_none
    end
    wait fork;

    cur_test = "byte_enables";
    for (int t = 0; t < NumTiles; t++) begin
      fork
        automatic int tt = t;
        repeat (50) tile_access(tt, tcdm_addr_t'($urandom), 1'b1, tcdm_data_t'($urandom),
                                tcdm_strb_t'($urandom));
      join_none
    end
    wait fork;
    read_all();

    cur_test = "fairness";
    for (int t = 0; t < NumTiles; t++) begin
      fork
        automatic int tt = t;
        for (int r = 0; r < 8; r++) begin
          tile_access(tt, tcdm_addr_t'((tt * 8 + r) * NumTiles + 2), 1'b0, '0, '0);
        end
      join_none
    end
    wait fork;

    cur_test = "dma_copy";
    run_dma(0, 128, 32);
    run_dma(40, 44, 16);
    cur_test = "dma_zero";
    run_dma(10, 200, 0);
    cur_test = "dma_check";
    read_all();

    cur_test = "dma_contention";
    copy_running = 1'b1;
    fork
      begin
        run_dma(64, 160, 48);
        copy_running = 1'b0;
      end
    join_none
    for (int t = 0; t < NumTiles; t++) begin
      fork
        automatic int tt = t;
        while (copy_running) begin
          tile_access(tt, tcdm_addr_t'($urandom_range(127)), 1'b0, '0, '0);
        end
      join_none
    end
    wait fork;
    read_all();

    repeat (4) @(posedge clk_i);
    $display("TEST OK");
    $finish;
  end

  initial begin
    #(TotalOps * (NumTiles + 2) * ClkPeriod);
    $display("Error test=%s watchdog expired before the tests ended", cur_test);
    $display("TEST FAILED");
    $fatal(1);
  end

endmodule

/* all.f */
+incdir+.
tcdm_pkg.sv
tcdm_bank.sv
bank_arbiter.sv
local_interco.sv
dma_copy_engine.sv
tcdm_group.sv
tb_tcdm_group.sv

/* Makefile */
SIM  := obj_dir/Vtb_tcdm_group
SRCS := tcdm_cfg.svh tcdm_pkg.sv tcdm_bank.sv bank_arbiter.sv local_interco.sv \
        dma_copy_engine.sv tcdm_group.sv tb_tcdm_group.sv

.PHONY: all run clean

all: run

$(SIM): $(SRCS) all.f
	verilator --binary --timing --assert -f all.f --top-module tb_tcdm_group \
	  -Mdir obj_dir -o Vtb_tcdm_group

run: $(SIM)
	-./$(SIM) | tee sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log
